/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // Register values, addresses and instruction words
  typedef logic [31:0] word_t;

  // Register index as it appears in the rs1, rs2 and rd fields
  typedef logic [4:0] reg_idx_t;

  // Instruction fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // Architectural register count and pc step
  localparam int num_regs = 32;
  localparam word_t insn_bytes = 32'd4;

  // Major opcodes still decoded by this core
  localparam opcode_t op_lui     = 7'b01_101_11;
  localparam opcode_t op_reg_imm = 7'b00_100_11;
  localparam opcode_t op_reg_reg = 7'b01_100_11;
  localparam opcode_t op_branch  = 7'b11_000_11;
  localparam opcode_t op_system  = 7'b11_100_11;

  // Branch conditions
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // ALU minor opcodes, shared by the immediate and register groups
  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_srl  = 3'b101;
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // Upper function field
  localparam funct7_t f7_base = 7'b000_0000;
  // SUB and SRA/SRAI form
  localparam funct7_t f7_alt  = 7'b010_0000;

endpackage

`default_nettype wire

/* rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

  // Run / halt machine in the pc unit
  typedef enum logic {
    st_run,
    st_halted
  } core_state_e;

  // Operations of the execute unit ALU
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_imm
  } exec_op_e;

endpackage

`default_nettype wire

/* rv_pc_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_pc_unit #(
  parameter rv_isa_pkg::word_t reset_pc = '0
) (
  input  wire                clk,
  input  wire                rst,
  input  rv_isa_pkg::word_t  insn,
  input  rv_isa_pkg::word_t  rs1_data,
  input  rv_isa_pkg::word_t  rs2_data,
  output rv_isa_pkg::word_t  pc,
  output logic               halted
);

  rv_isa_pkg::opcode_t     opcode;
  rv_isa_pkg::funct3_t     funct3;
  rv_isa_pkg::word_t       imm_b;
  rv_isa_pkg::word_t       next_pc;
  rv_core_pkg::core_state_e state;
  logic                    is_branch;
  logic                    is_ecall;
  logic                    equal;
  logic                    less_signed;
  logic                    less_unsigned;
  logic                    taken;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];

  // B-type offset, bit 0 is always zero
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};

  assign is_branch = (opcode == rv_isa_pkg::op_branch);
  // Only the plain ECALL encoding halts
  assign is_ecall  = (opcode == rv_isa_pkg::op_system) && (insn[31:7] == '0);

  assign equal         = (rs1_data == rs2_data);
  assign less_signed   = ($signed(rs1_data) < $signed(rs2_data));
  assign less_unsigned = (rs1_data < rs2_data);

  always_comb begin
    taken = 1'b0;
    if (is_branch) begin
      case (funct3)
        rv_isa_pkg::f3_beq:  taken = equal;
        rv_isa_pkg::f3_bne:  taken = !equal;
        rv_isa_pkg::f3_blt:  taken = less_signed;
        rv_isa_pkg::f3_bge:  taken = !less_signed;
        rv_isa_pkg::f3_bltu: taken = less_unsigned;
        rv_isa_pkg::f3_bgeu: taken = !less_unsigned;
        // Reserved branch encodings fall through as no-ops
        default:             taken = 1'b0;
      endcase
    end
  end

  assign next_pc = taken ? (pc + imm_b) : (pc + rv_isa_pkg::insn_bytes);

  // Once halted, pc and state freeze until the next reset
  always_ff @(posedge clk) begin
    if (rst) begin
      pc    <= reset_pc;
      state <= rv_core_pkg::st_run;
    end else if (state == rv_core_pkg::st_run) begin
      pc <= next_pc;
      if (is_ecall) begin
        state <= rv_core_pkg::st_halted;
      end
    end
  end

  assign halted = (state == rv_core_pkg::st_halted);

  // Taken branches must keep the fetch address word aligned
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
  );

  // Halt is sticky
  a_halt_sticky : assert property (
    @(posedge clk) disable iff (rst) halted |=> halted
  );

endmodule

`default_nettype wire

/* rv_reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_reg_file (
  input  wire                  clk,
  input  wire                  rst,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  output rv_isa_pkg::word_t    rs1_data,
  output rv_isa_pkg::word_t    rs2_data,
  input  wire                  wr_en,
  input  rv_isa_pkg::reg_idx_t wr_rd,
  input  rv_isa_pkg::word_t    wr_data
);

  rv_isa_pkg::word_t regs [rv_isa_pkg::num_regs];

  // Whole array cleared on reset, one write port otherwise
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_isa_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      // x0 filtering is done by the execute unit
      regs[wr_rd] <= wr_data;
    end
  end

  // x0 always reads as zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // Execute unit never issues a write to x0
  a_no_x0_write : assert property (
    @(posedge clk) disable iff (rst) wr_en |-> (wr_rd != '0)
  );

endmodule

`default_nettype wire

/* rv_exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_exec_unit (
  input  wire                  rst,
  input  wire                  halted,
  input  rv_isa_pkg::word_t    insn,
  input  rv_isa_pkg::word_t    rs1_data,
  input  rv_isa_pkg::word_t    rs2_data,
  output logic                 wr_en,
  output rv_isa_pkg::reg_idx_t wr_rd,
  output rv_isa_pkg::word_t    wr_data
);

  rv_isa_pkg::opcode_t      opcode;
  rv_isa_pkg::funct3_t      funct3;
  rv_isa_pkg::funct7_t      funct7;
  rv_isa_pkg::reg_idx_t     rd;
  rv_isa_pkg::word_t        imm_i;
  rv_isa_pkg::word_t        imm_u;
  rv_isa_pkg::word_t        shamt;
  rv_isa_pkg::word_t        operand_b;
  rv_isa_pkg::word_t        result;
  rv_core_pkg::exec_op_e    alu_op;
  logic                     is_shift;
  logic                     decode_ok;

  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // Immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};
  assign shamt = {27'b0, insn[24:20]};

  assign is_shift = (funct3 == rv_isa_pkg::f3_sll) || (funct3 == rv_isa_pkg::f3_srl);

  // Same funct3 map for both ALU groups, alt selects SUB/SRA
  function automatic rv_core_pkg::exec_op_e alu_op_of(
    input rv_isa_pkg::funct3_t f3,
    input logic                alt
  );
    rv_core_pkg::exec_op_e op;
    case (f3)
      rv_isa_pkg::f3_add:  op = alt ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
      rv_isa_pkg::f3_sll:  op = rv_core_pkg::alu_sll;
      rv_isa_pkg::f3_slt:  op = rv_core_pkg::alu_slt;
      rv_isa_pkg::f3_sltu: op = rv_core_pkg::alu_sltu;
      rv_isa_pkg::f3_xor:  op = rv_core_pkg::alu_xor;
      rv_isa_pkg::f3_srl:  op = alt ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
      rv_isa_pkg::f3_or:   op = rv_core_pkg::alu_or;
      default:             op = rv_core_pkg::alu_and;
    endcase
    return op;
  endfunction

  // Decode of LUI and the two ALU groups
  always_comb begin
    alu_op    = rv_core_pkg::alu_add;
    operand_b = '0;
    decode_ok = 1'b0;
    case (opcode)
      rv_isa_pkg::op_lui: begin
        alu_op    = rv_core_pkg::alu_pass_imm;
        operand_b = imm_u;
        decode_ok = 1'b1;
      end
      rv_isa_pkg::op_reg_imm: begin
        // funct7 is only meaningful for the immediate shifts
        alu_op = alu_op_of(funct3, (funct3 == rv_isa_pkg::f3_srl) &&
                                   (funct7 == rv_isa_pkg::f7_alt));
        if (is_shift) begin
          operand_b = shamt;
          decode_ok = (funct7 == rv_isa_pkg::f7_base) ||
                      ((funct3 == rv_isa_pkg::f3_srl) && (funct7 == rv_isa_pkg::f7_alt));
        end else begin
          operand_b = imm_i;
          decode_ok = 1'b1;
        end
      end
      rv_isa_pkg::op_reg_reg: begin
        alu_op = alu_op_of(funct3, funct7 == rv_isa_pkg::f7_alt);
        // Shift amount from the low five bits of rs2 only
        operand_b = is_shift ? {27'b0, rs2_data[4:0]} : rs2_data;
        decode_ok = (funct7 == rv_isa_pkg::f7_base) ||
                    ((funct7 == rv_isa_pkg::f7_alt) &&
                     ((funct3 == rv_isa_pkg::f3_add) || (funct3 == rv_isa_pkg::f3_srl)));
      end
      // Branches and system belong to the pc unit, others are no-ops
      default: begin
        decode_ok = 1'b0;
      end
    endcase
  end

  // ALU
  always_comb begin
    case (alu_op)
      rv_core_pkg::alu_add:  result = rs1_data + operand_b;
      rv_core_pkg::alu_sub:  result = rs1_data - operand_b;
      rv_core_pkg::alu_sll:  result = rs1_data << operand_b[4:0];
      rv_core_pkg::alu_slt:  result = {31'b0, $signed(rs1_data) < $signed(operand_b)};
      rv_core_pkg::alu_sltu: result = {31'b0, rs1_data < operand_b};
      rv_core_pkg::alu_xor:  result = rs1_data ^ operand_b;
      rv_core_pkg::alu_srl:  result = rs1_data >> operand_b[4:0];
      rv_core_pkg::alu_sra:  result = $signed(rs1_data) >>> operand_b[4:0];
      rv_core_pkg::alu_or:   result = rs1_data | operand_b;
      rv_core_pkg::alu_and:  result = rs1_data & operand_b;
      default:               result = operand_b;
    endcase
  end

  // Write-back, never to x0 and never after halt
  always_comb begin
    wr_en = decode_ok && (rd != '0) && !halted && !rst;
  end

  assign wr_rd   = rd;
  assign wr_data = result;

endmodule

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
  parameter rv_isa_pkg::word_t reset_pc = '0
) (
  input  wire                  clk,
  input  wire                  rst,
  output rv_isa_pkg::word_t    pc,
  input  rv_isa_pkg::word_t    insn,
  output logic                 halt,
  output logic                 wb_valid,
  output rv_isa_pkg::reg_idx_t wb_rd,
  output rv_isa_pkg::word_t    wb_data
);

  rv_isa_pkg::reg_idx_t rs1;
  rv_isa_pkg::reg_idx_t rs2;
  rv_isa_pkg::word_t    rs1_data;
  rv_isa_pkg::word_t    rs2_data;
  rv_isa_pkg::reg_idx_t wr_rd;
  rv_isa_pkg::word_t    wr_data;
  logic                 wr_en;
  logic                 halted;

  // Source register fields
  assign rs1 = insn[19:15];
  assign rs2 = insn[24:20];

  rv_pc_unit #(
    .reset_pc (reset_pc)
  ) i_pc_unit (
    .clk      (clk),
    .rst      (rst),
    .insn     (insn),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc),
    .halted   (halted)
  );

  rv_reg_file i_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wr_en),
    .wr_rd    (wr_rd),
    .wr_data  (wr_data)
  );

  rv_exec_unit i_exec_unit (
    .rst      (rst),
    .halted   (halted),
    .insn     (insn),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wr_en),
    .wr_rd    (wr_rd),
    .wr_data  (wr_data)
  );

  // Commit trace is the register file write port
  assign wb_valid = wr_en;
  assign wb_rd    = wr_rd;
  assign wb_data  = wr_data;
  assign halt     = halted;

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

  localparam rv_isa_pkg::word_t ecall_insn = 32'h0000_0073;
  localparam rv_isa_pkg::word_t fence_insn = 32'h0000_000f;

  logic                 clk;
  logic                 rst;
  logic                 halt;
  logic                 wb_valid;
  rv_isa_pkg::reg_idx_t wb_rd;
  rv_isa_pkg::word_t    pc;
  rv_isa_pkg::word_t    insn;
  rv_isa_pkg::word_t    wb_data;

  // Instruction memory and reference model state
  rv_isa_pkg::word_t imem [256];
  rv_isa_pkg::word_t m_regs [32];
  rv_isa_pkg::word_t m_pc;
  logic              m_halted;
  int                prog_len;
  int                errors;
  int                tests_run;
  int                tests_failed;
  integer            seed;

  assign insn = imem[pc[9:2]];

  rv_core i_dut (
    .clk      (clk),
    .rst      (rst),
    .pc       (pc),
    .insn     (insn),
    .halt     (halt),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input rv_isa_pkg::word_t actual, input rv_isa_pkg::word_t expected,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%-16s ok", name);
    end else begin
      tests_failed++;
      $display("%-16s %0d errors", name, errors - errors_before);
    end
  endtask

  // Unused words hold address-tagged FENCE encodings, which run as no-ops
  task automatic clear_program();
    for (int i = 0; i < 256; i++) begin
      imem[i] = {i[24:0], 7'b000_1111};
    end
    prog_len = 0;
  endtask

  task automatic emit(input rv_isa_pkg::word_t w);
    imem[prog_len[7:0]] = w;
    prog_len++;
  endtask

  function automatic rv_isa_pkg::word_t enc_r(input rv_isa_pkg::funct7_t f7,
      input rv_isa_pkg::reg_idx_t rs2, input rv_isa_pkg::reg_idx_t rs1,
      input rv_isa_pkg::funct3_t f3, input rv_isa_pkg::reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::op_reg_reg};
  endfunction

  function automatic rv_isa_pkg::word_t enc_i(input logic [11:0] imm,
      input rv_isa_pkg::reg_idx_t rs1, input rv_isa_pkg::funct3_t f3,
      input rv_isa_pkg::reg_idx_t rd);
    return {imm, rs1, f3, rd, rv_isa_pkg::op_reg_imm};
  endfunction

  function automatic rv_isa_pkg::word_t enc_lui(input logic [19:0] imm,
      input rv_isa_pkg::reg_idx_t rd);
    return {imm, rd, rv_isa_pkg::op_lui};
  endfunction

  function automatic rv_isa_pkg::word_t enc_b(input rv_isa_pkg::funct3_t f3,
      input rv_isa_pkg::reg_idx_t rs1, input rv_isa_pkg::reg_idx_t rs2, input int offset);
    logic [12:0] o;
    o = offset[12:0];
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], rv_isa_pkg::op_branch};
  endfunction

  // LUI takes the rounded upper part so that ADDI can add a signed low part
  task automatic load_const(input rv_isa_pkg::reg_idx_t rd, input rv_isa_pkg::word_t v);
    rv_isa_pkg::word_t upper;
    upper = v + 32'h800;
    emit(enc_lui(upper[31:12], rd));
    emit(enc_i(v[11:0], rd, rv_isa_pkg::f3_add, rd));
  endtask

  function automatic logic lt_signed(input rv_isa_pkg::word_t x, input rv_isa_pkg::word_t y);
    return (x[31] != y[31]) ? x[31] : (x < y);
  endfunction

  function automatic rv_isa_pkg::word_t sra_ref(input rv_isa_pkg::word_t x,
                                                input logic [4:0] s);
    return (x >> s) | ({32{x[31]}} & ~(32'hffff_ffff >> s));
  endfunction

  // Reference model of one instruction at m_pc
  task automatic predict(input rv_isa_pkg::word_t ins, output logic valid,
      output rv_isa_pkg::word_t data, output rv_isa_pkg::word_t npc, output logic ecall);
    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t b;
    rv_isa_pkg::word_t imm_i;
    rv_isa_pkg::word_t imm_b;
    logic [6:0]        f7;
    logic [2:0]        f3;
    logic [4:0]        sh;
    logic              base;
    logic              alt;
    logic              take;
    a     = m_regs[ins[19:15]];
    b     = m_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    f7    = ins[31:25];
    f3    = ins[14:12];
    base  = (f7 == 7'h00);
    alt   = (f7 == 7'h20);
    sh    = (ins[6:0] == rv_isa_pkg::op_reg_reg) ? b[4:0] : ins[24:20];
    valid = 1'b0;
    data  = '0;
    take  = 1'b0;
    ecall = 1'b0;
    if (ins[6:0] == rv_isa_pkg::op_lui) begin
      valid = 1'b1;
      data  = {ins[31:12], 12'h000};
    end else if (ins[6:0] == rv_isa_pkg::op_reg_imm || ins[6:0] == rv_isa_pkg::op_reg_reg) begin
      if (ins[6:0] == rv_isa_pkg::op_reg_reg) begin
        valid = base || (alt && (f3 == 3'd0 || f3 == 3'd5));
      end else begin
        b     = imm_i;
        valid = (f3 == 3'd1) ? base : ((f3 == 3'd5) ? (base || alt) : 1'b1);
        alt   = alt && (f3 == 3'd5);
      end
      case (f3)
        3'd0:    data = alt ? a - b : a + b;
        3'd1:    data = a << sh;
        3'd2:    data = {31'b0, lt_signed(a, b)};
        3'd3:    data = {31'b0, a < b};
        3'd4:    data = a ^ b;
        3'd5:    data = alt ? sra_ref(a, sh) : a >> sh;
        3'd6:    data = a | b;
        default: data = a & b;
      endcase
    end else if (ins[6:0] == rv_isa_pkg::op_branch) begin
      case (f3)
        3'd0:    take = (a == b);
        3'd1:    take = (a != b);
        3'd4:    take = lt_signed(a, b);
        3'd5:    take = !lt_signed(a, b);
        3'd6:    take = (a < b);
        3'd7:    take = !(a < b);
        default: take = 1'b0;
      endcase
    end else if (ins[6:0] == rv_isa_pkg::op_system) begin
      ecall = (ins[31:7] == '0);
    end
    valid = valid && (ins[11:7] != 5'd0);
    npc   = take ? m_pc + imm_b : m_pc + 32'd4;
  endtask

  // Sixteen cycles of reset, outputs checked once rst has taken effect
  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    for (int i = 0; i < 16; i++) begin
      @(negedge clk);
      check_value({31'b0, wb_valid}, 32'd0, "wb_valid in reset");
      if (i > 0) begin
        check_value(pc, 32'd0, "pc in reset");
        check_value({31'b0, halt}, 32'd0, "halt in reset");
      end
      @(posedge clk);
    end
    rst <= 1'b0;
  endtask

  // Runs the loaded program against the model until 20 cycles past halt
  task automatic run_program(input int max_cycles);
    rv_isa_pkg::word_t ins;
    rv_isa_pkg::word_t exp_data;
    rv_isa_pkg::word_t exp_pc;
    logic              exp_valid;
    logic              ecall;
    logic              was_halted;
    int                cycles;
    int                after_halt;
    apply_reset();
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    m_pc       = '0;
    m_halted   = 1'b0;
    cycles     = 0;
    after_halt = 0;
    while (after_halt < 20 && cycles < max_cycles) begin
      @(negedge clk);
      was_halted = m_halted;
      check_value(pc, m_pc, "pc");
      check_value({31'b0, halt}, {31'b0, m_halted}, "halt");
      ins = imem[m_pc[9:2]];
      predict(ins, exp_valid, exp_data, exp_pc, ecall);
      exp_valid = exp_valid && !m_halted;
      check_value({31'b0, wb_valid}, {31'b0, exp_valid}, "wb_valid");
      if (exp_valid) begin
        check_value({27'b0, wb_rd}, {27'b0, ins[11:7]}, "wb_rd");
        check_value(wb_data, exp_data, "wb_data");
        m_regs[ins[11:7]] = exp_data;
      end
      if (!m_halted) begin
        m_pc     = exp_pc;
        m_halted = ecall;
      end
      if (was_halted) begin
        after_halt++;
      end
      cycles++;
    end
    if (after_halt < 20) begin
      $display("Timeout: halt never rose within %0d cycles", max_cycles);
      errors++;
    end
  endtask

  task automatic test_reset_sequencing();
    int e0;
    e0 = errors;
    clear_program();
    emit(fence_insn);
    emit(32'h0ff0_000f);
    emit(enc_b(3'b010, 5'd1, 5'd2, 8));
    emit(enc_r(7'h01, 5'd2, 5'd1, rv_isa_pkg::f3_add, 5'd5));
    emit(32'h0080_006f);
    emit(32'h0000_0017 | (32'd6 << 7));
    emit(enc_i(12'h055, 5'd3, rv_isa_pkg::f3_add, 5'd0));
    emit(fence_insn);
    emit(ecall_insn);
    run_program(64);
    report_test("reset_sequence", e0);
  endtask

  task automatic test_imm_group();
    rv_isa_pkg::word_t r;
    int                e0;
    e0 = errors;
    clear_program();
    load_const(5'd1, $random(seed));
    r = $random(seed);
    load_const(5'd2, r | 32'h8000_0000);
    r = $random(seed);
    emit(enc_lui(r[19:0], 5'd5));
    emit(enc_i(12'hff9, 5'd1, rv_isa_pkg::f3_add, 5'd6));
    emit(enc_i(12'h7ff, 5'd2, rv_isa_pkg::f3_add, 5'd7));
    emit(enc_i(12'h800, 5'd1, rv_isa_pkg::f3_slt, 5'd8));
    emit(enc_i(12'h005, 5'd2, rv_isa_pkg::f3_slt, 5'd9));
    emit(enc_i(12'hfff, 5'd1, rv_isa_pkg::f3_sltu, 5'd10));
    emit(enc_i(12'h001, 5'd2, rv_isa_pkg::f3_sltu, 5'd11));
    emit(enc_i(12'hfff, 5'd1, rv_isa_pkg::f3_xor, 5'd12));
    emit(enc_i(r[31:20], 5'd2, rv_isa_pkg::f3_or, 5'd13));
    emit(enc_i(r[11:0], 5'd1, rv_isa_pkg::f3_and, 5'd14));
    emit(enc_i({rv_isa_pkg::f7_base, r[24:20]}, 5'd1, rv_isa_pkg::f3_sll, 5'd15));
    emit(enc_i({rv_isa_pkg::f7_base, r[28:24]}, 5'd2, rv_isa_pkg::f3_srl, 5'd16));
    emit(enc_i({rv_isa_pkg::f7_alt, r[28:24]}, 5'd2, rv_isa_pkg::f3_srl, 5'd17));
    emit(enc_i({rv_isa_pkg::f7_alt, 5'd31}, 5'd2, rv_isa_pkg::f3_srl, 5'd18));
    emit(enc_i({rv_isa_pkg::f7_alt, 5'd3}, 5'd2, rv_isa_pkg::f3_sll, 5'd19));
    emit(ecall_insn);
    run_program(64);
    report_test("imm_group", e0);
  endtask

  task automatic test_reg_group();
    rv_isa_pkg::word_t r;
    int                e0;
    e0 = errors;
    clear_program();
    load_const(5'd1, $random(seed));
    r = $random(seed);
    load_const(5'd2, r | 32'h8000_0000);
    r = $random(seed);
    load_const(5'd3, r & 32'h7fff_ffff);
    load_const(5'd4, $random(seed) | 32'hffff_ff00);
    emit(enc_r(rv_isa_pkg::f7_base, 5'd2, 5'd1, rv_isa_pkg::f3_add, 5'd5));
    emit(enc_r(rv_isa_pkg::f7_alt, 5'd2, 5'd1, rv_isa_pkg::f3_add, 5'd6));
    emit(enc_r(rv_isa_pkg::f7_alt, 5'd1, 5'd2, rv_isa_pkg::f3_add, 5'd7));
    emit(enc_r(rv_isa_pkg::f7_base, 5'd4, 5'd1, rv_isa_pkg::f3_sll, 5'd8));
    emit(enc_r(rv_isa_pkg::f7_base, 5'd3, 5'd2, rv_isa_pkg::f3_slt, 5'd9));
    emit(enc_r(rv_isa_pkg::f7_base, 5'd3, 5'd2, rv_isa_pkg::f3_sltu, 5'd10));
    emit(enc_r(rv_isa_pkg::f7_base, 5'd2, 5'd3, rv_isa_pkg::f3_slt, 5'd11));
    emit(enc_r(rv_isa_pkg::f7_base, 5'd2, 5'd3, rv_isa_pkg::f3_sltu, 5'd12));
    emit(enc_r(rv_isa_pkg::f7_base, 5'd2, 5'd1, rv_isa_pkg::f3_xor, 5'd13));
    emit(enc_r(rv_isa_pkg::f7_base, 5'd4, 5'd2, rv_isa_pkg::f3_srl, 5'd14));
    emit(enc_r(rv_isa_pkg::f7_alt, 5'd4, 5'd2, rv_isa_pkg::f3_srl, 5'd15));
    emit(enc_r(rv_isa_pkg::f7_base, 5'd2, 5'd1, rv_isa_pkg::f3_or, 5'd16));
    emit(enc_r(rv_isa_pkg::f7_base, 5'd2, 5'd1, rv_isa_pkg::f3_and, 5'd17));
    // Back-to-back dependent results
    emit(enc_r(rv_isa_pkg::f7_base, 5'd6, 5'd5, rv_isa_pkg::f3_add, 5'd18));
    emit(enc_r(rv_isa_pkg::f7_alt, 5'd13, 5'd18, rv_isa_pkg::f3_add, 5'd19));
    emit(enc_r(rv_isa_pkg::f7_alt, 5'd1, 5'd19, rv_isa_pkg::f3_srl, 5'd20));
    emit(enc_r(rv_isa_pkg::f7_alt, 5'd2, 5'd1, rv_isa_pkg::f3_xor, 5'd21));
    emit(ecall_insn);
    run_program(64);
    report_test("reg_group", e0);
  endtask

  task automatic test_reg_zero();
    int e0;
    e0 = errors;
    clear_program();
    load_const(5'd1, $random(seed));
    load_const(5'd2, $random(seed));
    emit(enc_i(12'h005, 5'd1, rv_isa_pkg::f3_add, 5'd0));
    emit(enc_r(rv_isa_pkg::f7_base, 5'd2, 5'd1, rv_isa_pkg::f3_add, 5'd0));
    emit(enc_lui(20'habcde, 5'd0));
    emit(enc_r(rv_isa_pkg::f7_alt, 5'd2, 5'd1, rv_isa_pkg::f3_add, 5'd0));
    emit(enc_r(rv_isa_pkg::f7_base, 5'd1, 5'd0, rv_isa_pkg::f3_add, 5'd5));
    emit(enc_r(rv_isa_pkg::f7_base, 5'd0, 5'd2, rv_isa_pkg::f3_add, 5'd6));
    emit(enc_i(12'hfff, 5'd0, rv_isa_pkg::f3_add, 5'd7));
    emit(ecall_insn);
    run_program(64);
    report_test("reg_zero", e0);
  endtask

  // Forward form skips an x10 increment, backward form reaches an x11 increment
  task automatic branch_pair(input rv_isa_pkg::funct3_t f3, input rv_isa_pkg::reg_idx_t rs1,
                             input rv_isa_pkg::reg_idx_t rs2);
    emit(enc_b(f3, rs1, rs2, 8));
    emit(enc_i(12'h001, 5'd10, rv_isa_pkg::f3_add, 5'd10));
    emit(enc_b(rv_isa_pkg::f3_beq, 5'd0, 5'd0, 12));
    emit(enc_i(12'h001, 5'd11, rv_isa_pkg::f3_add, 5'd11));
    emit(enc_b(rv_isa_pkg::f3_beq, 5'd0, 5'd0, 8));
    emit(enc_b(f3, rs1, rs2, -8));
  endtask

  task automatic test_branches();
    int e0;
    e0 = errors;
    clear_program();
    // x1 = -1, x2 = x3 = 1 separate signed from unsigned order
    emit(enc_i(12'hfff, 5'd0, rv_isa_pkg::f3_add, 5'd1));
    emit(enc_i(12'h001, 5'd0, rv_isa_pkg::f3_add, 5'd2));
    emit(enc_i(12'h001, 5'd0, rv_isa_pkg::f3_add, 5'd3));
    branch_pair(rv_isa_pkg::f3_beq, 5'd2, 5'd3);
    branch_pair(rv_isa_pkg::f3_beq, 5'd1, 5'd2);
    branch_pair(rv_isa_pkg::f3_bne, 5'd1, 5'd2);
    branch_pair(rv_isa_pkg::f3_bne, 5'd2, 5'd3);
    branch_pair(rv_isa_pkg::f3_blt, 5'd1, 5'd2);
    branch_pair(rv_isa_pkg::f3_blt, 5'd2, 5'd1);
    branch_pair(rv_isa_pkg::f3_bge, 5'd2, 5'd1);
    branch_pair(rv_isa_pkg::f3_bge, 5'd1, 5'd2);
    branch_pair(rv_isa_pkg::f3_bltu, 5'd2, 5'd1);
    branch_pair(rv_isa_pkg::f3_bltu, 5'd1, 5'd2);
    branch_pair(rv_isa_pkg::f3_bgeu, 5'd1, 5'd2);
    branch_pair(rv_isa_pkg::f3_bgeu, 5'd2, 5'd1);
    emit(ecall_insn);
    run_program(200);
    // Six cases are chosen taken and six not taken
    check_value(m_regs[10], 32'd6, "not-taken count");
    check_value(m_regs[11], 32'd6, "taken count");
    report_test("branches", e0);
  endtask

  task automatic test_halt();
    int e0;
    e0 = errors;
    clear_program();
    emit(enc_i(12'h123, 5'd0, rv_isa_pkg::f3_add, 5'd1));
    emit(enc_i(12'h001, 5'd1, rv_isa_pkg::f3_add, 5'd2));
    emit(ecall_insn);
    emit(enc_i(12'h005, 5'd0, rv_isa_pkg::f3_add, 5'd3));
    emit(enc_i(12'h006, 5'd0, rv_isa_pkg::f3_add, 5'd4));
    run_program(64);
    apply_reset();
    report_test("halt", e0);
  endtask

  initial begin
    rst          = 1'b1;
    seed         = 32'hef5a7fa8;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    clear_program();
    test_reset_sequencing();
    test_imm_group();
    test_reg_group();
    test_reg_zero();
    test_branches();
    test_halt();
    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
rv_isa_pkg.sv
rv_core_pkg.sv
rv_pc_unit.sv
rv_reg_file.sv
rv_exec_unit.sv
rv_core.sv
tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_rv_core -o sim_tb_rv_core \
  && ./obj_dir/sim_tb_rv_core | tee /dev/stderr | grep -x "test passed" > /dev/null \
  && echo "simulation result: PASS" \
  || { echo "simulation result: FAIL"; exit 1; }
